// File: common/dcache_pkg.sv
package dcache_pkg;

  //////////////////////////////
  // data widths
  //////////////////////////////

  typedef logic [127:0] line_t;  // one cache line
  typedef logic [63:0]  dword_t; // cpu data word

  localparam int LINE_BYTES = 16;
  localparam int BYTE_OFF_W = 4; // log2 of LINE_BYTES

  //////////////////////////////
  // store size
  //////////////////////////////

  typedef logic [1:0] store_src_t;

  localparam store_src_t STORE_B = 2'd0; // byte
  localparam store_src_t STORE_H = 2'd1; // halfword
  localparam store_src_t STORE_W = 2'd2; // word
  localparam store_src_t STORE_D = 2'd3; // doubleword

  //////////////////////////////
  // controller bundle
  //////////////////////////////

  // driven by the fsm, fanned out to the arrays and the dram model
  typedef struct packed {
    logic cache_wren;  // write the data array at the current index
    logic fill_sel;    // set when the line comes from dram
    logic set_valid;
    logic set_dirty;
    logic replace_tag;
    logic mem_wren;    // write-back request
    logic mem_rden;    // line fetch request
    logic tag_sel;     // set when the dram address uses the old tag
  } dcache_ctrl_t;

endpackage

// File: design/dram_model.sv
`timescale 1ns/1ns

module dram_model #(
  parameter int MEM_SIZE    = 1024, // bytes
  parameter int MEM_LATENCY = 4     // cycles before ready
) (
  input  logic                                                 i_riscv_dcache_clk,
  input  logic                                                 i_arst_n,
  input  logic [$clog2(MEM_SIZE/dcache_pkg::LINE_BYTES)-1:0] i_addr, // line address
  input  logic                                                 i_wren,
  input  logic                                                 i_rden,
  input  dcache_pkg::line_t                                    i_data,
  output dcache_pkg::line_t                                    o_data,
  output logic                                                 o_mem_ready
);

  localparam int DEPTH = MEM_SIZE / dcache_pkg::LINE_BYTES;
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  dcache_pkg::line_t mem_q [DEPTH];
  logic [CNT_W-1:0]  cnt_q;
  logic              req;

  assign req         = i_wren || i_rden;
  assign o_mem_ready = req && (cnt_q == CNT_W'(MEM_LATENCY)); // one cycle after the wait

  //////////////////////////////
  // latency counter
  //////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q <= '0;
    end else if (!req || o_mem_ready) begin
      cnt_q <= '0; // restart for the next request
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // storage, cleared at reset
  always_ff @(posedge i_riscv_dcache_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (o_mem_ready && i_wren) begin
      mem_q[i_addr] <= i_data;
    end
  end

  // read data held until the next read completes
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (o_mem_ready && i_rden) begin
      o_data <= mem_q[i_addr];
    end
  end

endmodule

// File: dcache/dcache_tag_array.sv
`timescale 1ns/1ns

module dcache_tag_array #(
  parameter int CACHE_DEPTH = 4,
  parameter int INDEX_W     = 2,
  parameter int TAG_W       = 4
) (
  input  logic                     i_riscv_dcache_clk,
  input  logic                     i_arst_n,
  input  logic [INDEX_W-1:0]       i_index,
  input  logic [TAG_W-1:0]         i_tag,
  input  dcache_pkg::dcache_ctrl_t i_ctrl,
  output logic                     o_hit,
  output logic                     o_dirty,
  output logic [TAG_W-1:0]         o_tag_old
);

  logic [TAG_W-1:0]       tag_q [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid_q;
  logic [CACHE_DEPTH-1:0] dirty_q;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_ctrl.replace_tag) begin
      tag_q[i_index] <= i_tag;
    end
  end

  always_ff @(posedge i_riscv_dcache_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (i_ctrl.set_valid) begin
        valid_q[i_index] <= 1'b1;
      end
      if (i_ctrl.replace_tag) begin
        dirty_q[i_index] <= 1'b0; // fresh line from dram is clean
      end else if (i_ctrl.set_dirty) begin
        dirty_q[i_index] <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // lookup
  //////////////////////////////

  assign o_tag_old = tag_q[i_index];
  assign o_hit     = valid_q[i_index] && (tag_q[i_index] == i_tag);
  assign o_dirty   = valid_q[i_index] && dirty_q[i_index]; // only a valid line needs write-back

  // the fsm only marks a line dirty after it has hit on it
  a_dirty_on_valid : assert property (
    @(posedge i_riscv_dcache_clk) disable iff (!i_arst_n)
    i_ctrl.set_dirty |-> valid_q[i_index]
  );

endmodule

// File: dcache/dcache_data_array.sv
`timescale 1ns/1ns

module dcache_data_array #(
  parameter int CACHE_DEPTH = 4,
  parameter int INDEX_W     = 2
) (
  input  logic                              i_riscv_dcache_clk,
  input  logic [INDEX_W-1:0]                i_index,
  input  logic [dcache_pkg::BYTE_OFF_W-1:0] i_byte_offset,
  input  dcache_pkg::store_src_t            i_store_src,
  input  dcache_pkg::dcache_ctrl_t          i_ctrl,
  input  dcache_pkg::dword_t                i_cpu_data,
  input  dcache_pkg::line_t                 i_fill_line,
  output dcache_pkg::line_t                 o_line
);

  dcache_pkg::line_t mem_q [CACHE_DEPTH];
  dcache_pkg::line_t merged;
  int                nbytes;

  // store width in bytes
  always_comb begin
    case (i_store_src)
      dcache_pkg::STORE_B: nbytes = 1;
      dcache_pkg::STORE_H: nbytes = 2;
      dcache_pkg::STORE_W: nbytes = 4;
      dcache_pkg::STORE_D: nbytes = 8;
      default:             nbytes = 8;
    endcase
  end

  //////////////////////////////
  // byte lane merge
  //////////////////////////////

  always_comb begin : lane_merge
    int rel;
    merged = mem_q[i_index];
    for (int k = 0; k < dcache_pkg::LINE_BYTES; k++) begin
      rel = k - int'(i_byte_offset); // lane position inside the store
      if (rel >= 0 && rel < nbytes) begin
        merged[k*8 +: 8] = i_cpu_data[rel*8 +: 8];
      end
    end
  end

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_ctrl.cache_wren) begin
      if (i_ctrl.fill_sel) begin
        mem_q[i_index] <= i_fill_line; // refill replaces the whole line
      end else begin
        mem_q[i_index] <= merged;
      end
    end
  end

  assign o_line = mem_q[i_index]; // async read

  // misaligned stores are not supported, so no store may spill past the line
  a_store_in_line : assert property (
    @(posedge i_riscv_dcache_clk)
    (i_ctrl.cache_wren && !i_ctrl.fill_sel) |->
      (int'(i_byte_offset) + nbytes <= dcache_pkg::LINE_BYTES)
  );

endmodule

// File: dcache/dcache_fsm.sv
`timescale 1ns/1ns

module dcache_fsm (
  input  logic                     i_riscv_dcache_clk,
  input  logic                     i_arst_n,
  input  logic                     i_cpu_wren,
  input  logic                     i_cpu_rden,
  input  logic                     i_hit,
  input  logic                     i_dirty,
  input  logic                     i_mem_ready,
  output dcache_pkg::dcache_ctrl_t o_ctrl,
  output logic                     o_stall
);

  typedef enum logic [1:0] {
    LOOKUP,
    WRITE_BACK,
    ALLOCATE,
    REFILL
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   req;

  assign req = i_cpu_wren || i_cpu_rden;

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= LOOKUP;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    o_ctrl  = '0;

    case (state_q)
      LOOKUP: begin
        if (req) begin
          if (i_hit) begin
            if (i_cpu_wren) begin       // store and mark dirty on a write hit
              o_ctrl.cache_wren = 1'b1;
              o_ctrl.set_dirty  = 1'b1;
            end
          end else if (i_dirty) begin
            state_d = WRITE_BACK;       // evict the old line first
          end else begin
            state_d = ALLOCATE;
          end
        end
      end

      WRITE_BACK: begin
        o_ctrl.mem_wren = 1'b1;
        o_ctrl.tag_sel  = 1'b1;         // address of the line being evicted
        if (i_mem_ready) begin
          state_d = ALLOCATE;
        end
      end

      ALLOCATE: begin
        o_ctrl.mem_rden = 1'b1;
        if (i_mem_ready) begin
          state_d = REFILL;
        end
      end

      REFILL: begin
        // dram data is registered by now
        o_ctrl.cache_wren  = 1'b1;
        o_ctrl.fill_sel    = 1'b1;
        o_ctrl.replace_tag = 1'b1;
        o_ctrl.set_valid   = 1'b1;
        state_d            = LOOKUP;
      end

      default: begin
        state_d = LOOKUP;
      end
    endcase
  end

  // only a lookup hit lets the request through
  assign o_stall = req && !(state_q == LOOKUP && i_hit);

  a_one_mem_req : assert property (
    @(posedge i_riscv_dcache_clk) disable iff (!i_arst_n)
    !(o_ctrl.mem_wren && o_ctrl.mem_rden)
  );

endmodule

// File: dcache/riscv_data_cache.sv
`timescale 1ns/1ns

module riscv_data_cache #(
  parameter int MEM_SIZE    = 1024, // bytes
  parameter int CACHE_SIZE  = 64,   // bytes
  parameter int MEM_LATENCY = 4
) (
  input  logic                    i_riscv_dcache_clk,
  input  logic                    i_arst_n,
  input  logic                    i_riscv_dcache_cpu_wren,
  input  logic                    i_riscv_dcache_cpu_rden,
  input  dcache_pkg::store_src_t  i_riscv_dcache_store_src,
  input  logic [63:0]             i_riscv_dcache_phys_addr,
  input  dcache_pkg::dword_t      i_riscv_dcache_cpu_data_in,
  output dcache_pkg::dword_t      o_riscv_dcache_cpu_data_out,
  output logic                    o_riscv_dcache_cpu_stall
);

  localparam int CACHE_DEPTH = CACHE_SIZE / dcache_pkg::LINE_BYTES;
  localparam int ADDR        = $clog2(MEM_SIZE);
  localparam int INDEX_W     = $clog2(CACHE_DEPTH);
  localparam int TAG_W       = ADDR - dcache_pkg::BYTE_OFF_W - INDEX_W;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  tag_t                          tag;
  index_t                        index;
  logic [dcache_pkg::BYTE_OFF_W-1:0] byte_offset;

  dcache_pkg::dcache_ctrl_t ctrl;
  dcache_pkg::line_t        cache_line;
  dcache_pkg::line_t        fill_line;
  dcache_pkg::line_t        dram_line;
  logic                     hit;
  logic                     dirty;
  tag_t                     tag_old;
  logic                     mem_ready;
  logic [TAG_W+INDEX_W-1:0] mem_addr;

  //////////////////////////////
  // address split and muxes
  //////////////////////////////

  assign tag         = i_riscv_dcache_phys_addr[ADDR-1 -: TAG_W];
  assign index       = i_riscv_dcache_phys_addr[dcache_pkg::BYTE_OFF_W +: INDEX_W];
  assign byte_offset = i_riscv_dcache_phys_addr[dcache_pkg::BYTE_OFF_W-1:0];

  // write-back goes to the evicted line's address
  assign mem_addr  = ctrl.tag_sel ? {tag_old, index} : {tag, index};
  assign fill_line = ctrl.fill_sel ? dram_line : cache_line; // idle input follows stored line

  assign o_riscv_dcache_cpu_data_out = i_riscv_dcache_phys_addr[3] ? cache_line[127:64]
                                                                   : cache_line[63:0];

  //////////////////////////////
  // blocks
  //////////////////////////////

  dcache_tag_array #(
    .CACHE_DEPTH (CACHE_DEPTH),
    .INDEX_W     (INDEX_W),
    .TAG_W       (TAG_W)
  ) u_tag_array (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_arst_n           (i_arst_n),
    .i_index            (index),
    .i_tag              (tag),
    .i_ctrl             (ctrl),
    .o_hit              (hit),
    .o_dirty            (dirty),
    .o_tag_old          (tag_old)
  );

  dcache_data_array #(
    .CACHE_DEPTH (CACHE_DEPTH),
    .INDEX_W     (INDEX_W)
  ) u_data_array (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_index            (index),
    .i_byte_offset      (byte_offset),
    .i_store_src        (i_riscv_dcache_store_src),
    .i_ctrl             (ctrl),
    .i_cpu_data         (i_riscv_dcache_cpu_data_in),
    .i_fill_line        (fill_line),
    .o_line             (cache_line)
  );

  dcache_fsm u_cache_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_arst_n           (i_arst_n),
    .i_cpu_wren         (i_riscv_dcache_cpu_wren),
    .i_cpu_rden         (i_riscv_dcache_cpu_rden),
    .i_hit              (hit),
    .i_dirty            (dirty),
    .i_mem_ready        (mem_ready),
    .o_ctrl             (ctrl),
    .o_stall            (o_riscv_dcache_cpu_stall)
  );

  dram_model #(
    .MEM_SIZE    (MEM_SIZE),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_arst_n           (i_arst_n),
    .i_addr             (mem_addr),
    .i_wren             (ctrl.mem_wren),
    .i_rden             (ctrl.mem_rden),
    .i_data             (cache_line),
    .o_data             (dram_line),
    .o_mem_ready        (mem_ready)
  );

endmodule

// File: tests/tb_riscv_data_cache.sv
`timescale 1ns/1ns

module tb_riscv_data_cache;

  localparam int          MEM_SIZE    = 1024; // same as the dut default
  localparam int          MEM_LATENCY = 4;    // same as the dut default
  localparam logic [31:0] LFSR_SEED   = 32'hd42d_30fa;

  typedef struct packed {
    logic                   wr;
    logic [63:0]            addr;
    dcache_pkg::store_src_t size;
    dcache_pkg::dword_t     data;
    dcache_pkg::dword_t     exp;     // expected read data
    logic                   exp_hit; // stall low when first presented
  } entry_t;

  logic                   clk;
  logic                   i_arst_n;
  logic                   cpu_wren;
  logic                   cpu_rden;
  dcache_pkg::store_src_t store_src;
  logic [63:0]            phys_addr;
  dcache_pkg::dword_t     cpu_data_in;
  dcache_pkg::dword_t     cpu_data_out;
  logic                   cpu_stall;

  entry_t      stim_q [$];
  logic [7:0]  shadow [MEM_SIZE]; // flat byte image of memory
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycle_limit;
  int          cycle_count;

  riscv_data_cache u_dut (
    .i_riscv_dcache_clk          (clk),
    .i_arst_n                    (i_arst_n),
    .i_riscv_dcache_cpu_wren     (cpu_wren),
    .i_riscv_dcache_cpu_rden     (cpu_rden),
    .i_riscv_dcache_store_src    (store_src),
    .i_riscv_dcache_phys_addr    (phys_addr),
    .i_riscv_dcache_cpu_data_in  (cpu_data_in),
    .o_riscv_dcache_cpu_data_out (cpu_data_out),
    .o_riscv_dcache_cpu_stall    (cpu_stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic dcache_pkg::dword_t random_dword();
    dcache_pkg::dword_t v;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // stores write the low bytes from the byte offset, reads return the aligned dword
  task automatic add_entry(input logic wr, input logic [63:0] addr,
                           input dcache_pkg::store_src_t size,
                           input dcache_pkg::dword_t data, input logic exp_hit);
    entry_t e;
    int     nbytes;
    int     base;
    nbytes    = 1 << size;
    e.wr      = wr;
    e.addr    = addr;
    e.size    = size;
    e.data    = data;
    e.exp_hit = exp_hit;
    e.exp     = '0;
    if (wr) begin
      for (int i = 0; i < nbytes; i++) begin
        shadow[int'(addr[9:0]) + i] = data[i*8 +: 8];
      end
    end else begin
      base = int'(addr[9:0]) & ~7;
      for (int i = 0; i < 8; i++) begin
        e.exp[i*8 +: 8] = shadow[base + i];
      end
    end
    stim_q.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e);
    @(posedge clk);
    #1;
    cpu_wren    = e.wr;
    cpu_rden    = !e.wr;
    phys_addr   = e.addr;
    store_src   = e.size;
    cpu_data_in = e.data;
    @(negedge clk);
    compare_value("o_riscv_dcache_cpu_stall", 64'(cpu_stall), 64'(!e.exp_hit));
    while (cpu_stall) begin
      @(negedge clk); // miss in progress
    end
    if (!e.wr) begin
      compare_value("o_riscv_dcache_cpu_data_out", cpu_data_out, e.exp);
    end
  endtask

  //////////////////////////////
  // timeout
  //////////////////////////////

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the cache did not finish the test sequence in %0d cycles", cycle_limit);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    i_arst_n    = 1'b0;
    cpu_wren    = 1'b0;
    cpu_rden    = 1'b0;
    store_src   = dcache_pkg::STORE_D;
    phys_addr   = '0;
    cpu_data_in = '0;
    errors      = 0;
    checks      = 0;
    cycle_limit = 0;
    lfsr_state  = LFSR_SEED;
    for (int i = 0; i < MEM_SIZE; i++) begin
      shadow[i] = 8'h00; // dram starts zeroed
    end

    add_entry(1'b0, 64'h000, dcache_pkg::STORE_D, '0, 1'b0);   // cold miss reads zero
    add_entry(1'b0, 64'h008, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b1, 64'h000, dcache_pkg::STORE_D, random_dword(), 1'b1);
    add_entry(1'b1, 64'h008, dcache_pkg::STORE_D, random_dword(), 1'b1);
    add_entry(1'b0, 64'h000, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b0, 64'h008, dcache_pkg::STORE_D, '0, 1'b1);   // upper half separate
    add_entry(1'b1, 64'h002, dcache_pkg::STORE_B, 64'hffff_ffff_ffff_ff5a, 1'b1);
    add_entry(1'b1, 64'h00c, dcache_pkg::STORE_H, 64'hffff_ffff_ffff_c3e1, 1'b1);
    add_entry(1'b1, 64'h004, dcache_pkg::STORE_W, 64'hffff_ffff_1234_5678, 1'b1);
    add_entry(1'b0, 64'h000, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b0, 64'h008, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b1, 64'h110, dcache_pkg::STORE_D, random_dword(), 1'b0); // write allocate
    add_entry(1'b0, 64'h050, dcache_pkg::STORE_D, '0, 1'b0);   // evicts dirty 0x110
    add_entry(1'b0, 64'h110, dcache_pkg::STORE_D, '0, 1'b0);
    add_entry(1'b0, 64'h0c0, dcache_pkg::STORE_D, '0, 1'b0);   // evicts merged line 0
    add_entry(1'b0, 64'h000, dcache_pkg::STORE_D, '0, 1'b0);
    add_entry(1'b0, 64'h008, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b1, 64'h028, dcache_pkg::STORE_D, random_dword(), 1'b0);
    add_entry(1'b0, 64'h028, dcache_pkg::STORE_D, '0, 1'b1);
    add_entry(1'b0, 64'h020, dcache_pkg::STORE_D, '0, 1'b1);   // refilled half stays zero

    cycle_limit = stim_q.size() * (2 * MEM_LATENCY + 6) + 50;

    repeat (8) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    @(negedge clk);
    compare_value("o_riscv_dcache_cpu_stall", 64'(cpu_stall), 64'd0); // idle

    foreach (stim_q[n]) begin
      apply_entry(stim_q[n]);
    end
    @(posedge clk);
    #1;
    cpu_wren = 1'b0;
    cpu_rden = 1'b0;

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
common/dcache_pkg.sv
design/dram_model.sv
dcache/dcache_tag_array.sv
dcache/dcache_data_array.sv
dcache/dcache_fsm.sv
dcache/riscv_data_cache.sv
tests/tb_riscv_data_cache.sv

// File: Bender.yml
package:
  name: riscv_data_cache

sources:
  - common/dcache_pkg.sv
  - design/dram_model.sv
  - dcache/dcache_tag_array.sv
  - dcache/dcache_data_array.sv
  - dcache/dcache_fsm.sv
  - dcache/riscv_data_cache.sv
  - target: test
    files:
      - tests/tb_riscv_data_cache.sv
